//--- bench/debugSocTb.sv
module debugSocTb;
    timeunit 1ns;
    timeprecision 1ps;

    import memPkg::*;
    import uartPkg::*;

    // one line of the vector file
    typedef struct packed {
        logic [7:0]          op;
        logic [1:0]          width;
        logic                signedRead;
        logic [addrBits-1:0] addr;
        logic [31:0]         wdata;
        logic [31:0]         rdata;
        logic                misaligned;
    } vecLine;

    logic   clk;
    logic   rstN;
    logic   req;
    busReq  hostReq;
    logic   ack;
    busRsp  hostRsp;
    logic   btnN;
    logic   tx;

    vecLine      vectors [$];
    logic [31:0] rngState;
    logic        reqSeen;
    int          limitCycles;

    debugSoc i_dut (
        .clk     (clk),
        .rstN    (rstN),
        .req     (req),
        .hostReq (hostReq),
        .ack     (ack),
        .hostRsp (hostRsp),
        .btnN    (btnN),
        .tx      (tx)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic checkRsp(input busRsp got, input busRsp exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf(
                {"CHECK FAILED at %0d ns: %s rdata %h misaligned %b,",
                 " expected rdata %h misaligned %b"},
                $time, what, got.rdata, got.misaligned, exp.rdata, exp.misaligned));
        end
    endtask

    task automatic checkByte(input serialByte got, input serialByte exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("CHECK FAILED at %0d ns: %s got byte %h, expected %h",
                $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 0 to 7 idle cycles
    task automatic idleGap();
        rngState = xorshift32(rngState);
        repeat (int'(rngState[2:0])) @(posedge clk);
    endtask

    task automatic loadVectors();
        int          fd;
        int          n;
        int          w;
        int          s;
        int          m;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] r;
        string       line;
        vecLine      v;
        fd = $fopen("bench/debugSocVectors.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open bench/debugSocVectors.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %d %d %h %h %h %d", op, w, s, a, d, r, m);
            if (n != 7) begin
                abortRun($sformatf("malformed vector line %s", line));
            end
            v.op         = op;
            v.width      = w[1:0];
            v.signedRead = s[0];
            v.addr       = a[addrBits-1:0];
            v.wdata      = d;
            v.rdata      = r;
            v.misaligned = m[0];
            vectors.push_back(v);
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            abortRun("the vector file holds no operations");
        end
        // worst case per line is two dumps with their hold times and the idle waits
        limitCycles = 100 + vectors.size() * 2 *
            (2 * (40 * bitCycles + holdCycles) + 2 * holdCycles + 6 * bitCycles + 64);
    endtask

    task automatic hostAccess(input busReq r, input busRsp exp, input string what);
        int waited;
        waited = 0;
        @(posedge clk);
        hostReq <= r;
        req     <= 1'b1;
        reqSeen = 1'b1;
        // 16 cycles is far beyond the two-cycle access
        while (ack !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > 16) begin
                abortRun($sformatf("no ack for %s", what));
            end
        end
        checkRsp(hostRsp, exp, what);
        idleGap();
        // req is still held, so ack has to stay up
        @(negedge clk);
        if (ack !== 1'b1) begin
            abortRun($sformatf("ack fell while req was still high for %s", what));
        end
        @(posedge clk);
        req <= 1'b0;
        waited = 0;
        while (ack !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > 16) begin
                abortRun($sformatf("ack stayed high after req fell for %s", what));
            end
        end
    endtask

    // samples in the middle of each bit, on the falling clock edge
    task automatic receiveByte(output serialByte b);
        @(negedge tx);
        repeat (bitCycles / 2) @(negedge clk);
        if (tx !== 1'b0) begin
            abortRun("start bit did not stay low up to its middle");
        end
        for (int i = 0; i < 8; i++) begin
            repeat (bitCycles) @(negedge clk);
            b[i] = tx;
        end
        repeat (bitCycles) @(negedge clk);
        if (tx !== 1'b1) begin
            abortRun("stop bit was low on the serial line");
        end
    endtask

    task automatic receiveWord(input logic [31:0] expWord, input string what);
        serialByte got;
        for (int i = 0; i < 4; i++) begin
            receiveByte(got);
            checkByte(got, expWord[31 - 8 * i -: 8], $sformatf("%s byte %0d", what, i));
        end
    endtask

    task automatic runDump(input logic [31:0] expWord, input string what);
        @(posedge clk);
        btnN <= 1'b0;
        receiveWord(expWord, what);
        // button still held, the line must stay idle past the hold time
        repeat (holdCycles + 4 * bitCycles) begin
            @(negedge clk);
            if (tx !== 1'b1) begin
                abortRun($sformatf("a second dump started while the button was held, %s",
                    what));
            end
        end
        @(posedge clk);
        btnN <= 1'b1;
        repeat (2) @(posedge clk);
        btnN <= 1'b0;
        receiveWord(expWord, {what, " repeat"});
        @(posedge clk);
        btnN <= 1'b1;
        repeat (holdCycles + bitCycles + 4) @(posedge clk);
    endtask

    task automatic runVector(input vecLine v, input int idx);
        busReq r;
        busRsp exp;
        string what;
        r.write        = (v.op == "W");
        r.signedRead   = v.signedRead;
        r.width        = memWidth'(v.width);
        r.addr         = v.addr;
        r.wdata        = v.wdata;
        exp.rdata      = v.rdata;
        exp.misaligned = v.misaligned;
        what = $sformatf("vector %0d op %c addr %h", idx, v.op, v.addr);
        case (v.op)
            "W", "L": hostAccess(r, exp, what);
            "D": runDump(v.rdata, what);
            default: abortRun($sformatf("vector %0d has an unknown op letter", idx));
        endcase
    endtask

    // nothing may move on the outputs before the first request
    always @(negedge clk) begin
        if (rstN === 1'b1 && !reqSeen) begin
            if (ack !== 1'b0) begin
                abortRun("ack was high before any request");
            end
            if (tx !== 1'b1) begin
                abortRun("tx left the idle level before any dump");
            end
        end
    end

    initial begin
        wait (limitCycles > 0);
        repeat (limitCycles) @(posedge clk);
        abortRun($sformatf("timeout after %0d cycles without the run finishing", limitCycles));
    end

    initial begin
        req         = 1'b0;
        hostReq     = '0;
        btnN        = 1'b1;
        rstN        = 1'b0;
        rngState    = 32'd89162;
        reqSeen     = 1'b0;
        limitCycles = 0;
        loadVectors();
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        repeat (6) @(posedge clk);
        foreach (vectors[i]) begin
            idleGap();
            runVector(vectors[i], i);
        end
        repeat (2) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- bench/debugSocVectors.txt
# op width signed addr data rdata misaligned, with addr and the data words in hex
# width 0 byte, 1 half, 2 word; a D line expects its rdata word on tx, msb first
W 2 0 010 deadbeef 00000000 0
L 2 0 010 00000000 deadbeef 0
D 0 0 000 00000000 deadbeef 0
W 2 0 020 11223344 00000000 0
W 0 0 021 000000a5 00000000 0
W 1 0 022 00007e80 00000000 0
L 2 0 020 00000000 7e80a544 0
L 0 1 021 00000000 ffffffa5 0
L 0 0 021 00000000 000000a5 0
L 0 1 023 00000000 0000007e 0
L 0 1 022 00000000 ffffff80 0
L 1 1 022 00000000 00007e80 0
L 1 0 020 00000000 0000a544 0
L 1 1 020 00000000 ffffa544 0
W 2 0 022 cafef00d 00000000 1
W 1 0 021 00000bad 00000000 1
L 2 0 012 00000000 00000000 1
L 1 1 013 00000000 00000000 1
L 2 0 020 00000000 7e80a544 0
D 0 0 000 00000000 7e80a544 0
W 2 0 3fc 80000001 00000000 0
L 1 1 3fe 00000000 ffff8000 0
D 0 0 000 00000000 ffff8000 0

//--- rtl/debugSoc.sv
module debugSoc (
    input  logic          clk,
    input  logic          rstN,
    input  logic          req,
    input  memPkg::busReq hostReq,
    output logic          ack,
    output memPkg::busRsp hostRsp,
    input  logic          btnN,
    output logic          tx
);
    import memPkg::*;

    busReq       accReq;
    logic        accGo;
    ramPort      ramBus;
    logic [31:0] rdWord;
    logic [31:0] loadData;
    logic [31:0] lastLoad;

    memCtrl ctrlInst (
        .clk      (clk),
        .rstN     (rstN),
        .req      (req),
        .hostReq  (hostReq),
        .ack      (ack),
        .hostRsp  (hostRsp),
        .accReq   (accReq),
        .accGo    (accGo),
        .loadData (loadData),
        .lastLoad (lastLoad)
    );

    laneAlign alignInst (
        .accReq   (accReq),
        .accGo    (accGo),
        .ram      (ramBus),
        .rdWord   (rdWord),
        .loadData (loadData)
    );

    memArray arrayInst (
        .clk    (clk),
        .ram    (ramBus),
        .rdWord (rdWord)
    );

    // serial dump of the last aligned load
    wordDumpTx dumpInst (
        .clk  (clk),
        .rstN (rstN),
        .btnN (btnN),
        .word (lastLoad),
        .tx   (tx)
    );

endmodule

//--- rtl/laneAlign.sv
module laneAlign (
    input  memPkg::busReq  accReq,
    input  logic           accGo,
    output memPkg::ramPort ram,
    input  logic [31:0]    rdWord,
    output logic [31:0]    loadData
);
    import memPkg::*;

    logic [1:0]  offset;
    logic [4:0]  shiftBits;
    logic        storeEn;
    logic [31:0] laneWord;

    assign offset    = accReq.addr[1:0];
    assign shiftBits = {offset, 3'b000};
    assign storeEn   = accGo && accReq.write;

    // store side, data moved up into the addressed lanes
    always_comb begin
        ram.wordIndex = accReq.addr[addrBits-1:2];
        ram.byteEn    = 4'b0000;
        case (accReq.width)
            widthByte: begin
                ram.wdata = {24'b0, accReq.wdata[7:0]} << shiftBits;
                if (storeEn) begin
                    ram.byteEn = 4'b0001 << offset;
                end
            end
            widthHalf: begin
                ram.wdata = {16'b0, accReq.wdata[15:0]} << shiftBits;
                if (storeEn) begin
                    ram.byteEn = 4'b0011 << offset;
                end
            end
            default: begin
                ram.wdata = accReq.wdata;
                if (storeEn) begin
                    ram.byteEn = 4'b1111;
                end
            end
        endcase
    end

    // load side, addressed lanes brought down to bit 0
    assign laneWord = rdWord >> shiftBits;

    always_comb begin
        case (accReq.width)
            widthByte: begin
                if (accReq.signedRead) begin
                    loadData = {{24{laneWord[7]}}, laneWord[7:0]};
                end else begin
                    loadData = {24'b0, laneWord[7:0]};
                end
            end
            widthHalf: begin
                if (accReq.signedRead) begin
                    loadData = {{16{laneWord[15]}}, laneWord[15:0]};
                end else begin
                    loadData = {16'b0, laneWord[15:0]};
                end
            end
            default: begin
                loadData = rdWord;
            end
        endcase
    end

endmodule

//--- rtl/memArray.sv
module memArray (
    input  logic           clk,
    input  memPkg::ramPort ram,
    output logic [31:0]    rdWord
);
    import memPkg::*;

    logic [31:0] mem [memWords];

    // zeroed so that reads of unwritten words are defined
    initial begin
        for (int i = 0; i < memWords; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (ram.byteEn[lane]) begin
                mem[ram.wordIndex][lane*8 +: 8] <= ram.wdata[lane*8 +: 8];
            end
        end
        // read returns the word as it was before this edge
        rdWord <= mem[ram.wordIndex];
    end

    legalByteEn: assert property (
        @(posedge clk)
        ram.byteEn inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                           4'b0011, 4'b1100, 4'b1111}
    ) else $error("illegal byte enable pattern %b", ram.byteEn);

endmodule

//--- rtl/memCtrl.sv
module memCtrl (
    input  logic          clk,
    input  logic          rstN,
    input  logic          req,
    input  memPkg::busReq hostReq,
    output logic          ack,
    output memPkg::busRsp hostRsp,
    output memPkg::busReq accReq,
    output logic          accGo,
    input  logic [31:0]   loadData,
    output logic [31:0]   lastLoad
);
    import memPkg::*;

    ctrlState state;
    logic     misaligned;

    // half needs addr[0] clear, word needs addr[1:0] clear
    always_comb begin
        unique case (accReq.width)
            widthByte: misaligned = 1'b0;
            widthHalf: misaligned = accReq.addr[0];
            default:   misaligned = |accReq.addr[1:0];
        endcase
    end

    // RAM is touched in ctrlRead only, never for a misaligned access
    assign accGo = (state == ctrlRead) && !misaligned;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= ctrlIdle;
            ack      <= 1'b0;
            lastLoad <= '0;
        end else begin
            unique case (state)
                ctrlIdle: begin
                    if (req) begin
                        accReq <= hostReq;
                        state  <= ctrlRead;
                    end
                end
                ctrlRead: begin
                    state <= ctrlAck;
                end
                ctrlAck: begin
                    // registered read data is valid now
                    hostRsp.misaligned <= misaligned;
                    if (misaligned || accReq.write) begin
                        hostRsp.rdata <= '0;
                    end else begin
                        hostRsp.rdata <= loadData;
                        lastLoad      <= loadData;
                    end
                    ack   <= 1'b1;
                    state <= ctrlRelease;
                end
                ctrlRelease: begin
                    // ack follows req down
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= ctrlIdle;
                    end
                end
            endcase
        end
    end

    ackNeedsReq: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(ack) |-> req
    ) else $error("ack raised while req is low");

    accReqStable: assert property (
        @(posedge clk) disable iff (!rstN)
        ack |-> $stable(accReq)
    ) else $error("access request changed while ack is high");

endmodule

//--- rtl/memPkg.sv
package memPkg;

    // byte address space of the RAM
    localparam int addrBits = 10;
    localparam int indexBits = addrBits - 2;
    localparam int memWords = 256;

    // access size, doubles as the opcode of an access
    typedef enum logic [1:0] {
        widthByte = 2'd0,
        widthHalf = 2'd1,
        widthWord = 2'd2
    } memWidth;

    typedef enum logic [1:0] {
        ctrlIdle    = 2'd0,
        ctrlRead    = 2'd1,
        ctrlAck     = 2'd2,
        ctrlRelease = 2'd3
    } ctrlState;

    // host request, held stable for the whole handshake
    typedef struct packed {
        logic                write;
        logic                signedRead;
        memWidth             width;
        logic [addrBits-1:0] addr;
        logic [31:0]         wdata;
    } busReq;

    typedef struct packed {
        logic [31:0] rdata;
        logic        misaligned;
    } busRsp;

    // word-wide RAM port with one enable per byte lane
    typedef struct packed {
        logic [3:0]           byteEn;
        logic [indexBits-1:0] wordIndex;
        logic [31:0]          wdata;
    } ramPort;

endpackage

//--- rtl/uartPkg.sv
package uartPkg;

    // short bit and hold times for simulation
    localparam int bitCycles = 8;
    localparam int holdCycles = 32;

    // one timer serves both the bit time and the hold time
    localparam int timerBits = $clog2(holdCycles) + 1;

    typedef enum logic [2:0] {
        txIdle  = 3'd0,
        txStart = 3'd1,
        txData  = 3'd2,
        txStop  = 3'd3,
        txHold  = 3'd4
    } txState;

    typedef logic [7:0] serialByte;

endpackage

//--- rtl/wordDumpTx.sv
module wordDumpTx (
    input  logic        clk,
    input  logic        rstN,
    input  logic        btnN,
    input  logic [31:0] word,
    output logic        tx
);
    import uartPkg::*;

    txState                 state;
    logic [timerBits-1:0]   timer;
    logic [2:0]             bitIdx;
    logic [1:0]             byteIdx;
    serialByte              frameBuf [4];
    serialByte              curByte;
    logic                   bitEnd;
    logic                   holdEnd;

    assign bitEnd  = (timer == timerBits'(bitCycles - 1));
    assign holdEnd = (timer == timerBits'(holdCycles - 1));

    // tx is registered and changes together with the state
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= txIdle;
            tx      <= 1'b1;
            timer   <= '0;
            bitIdx  <= '0;
            byteIdx <= '0;
        end else begin
            case (state)
                txIdle: begin
                    if (!btnN) begin
                        // msb first on the line
                        frameBuf[0] <= word[31:24];
                        frameBuf[1] <= word[23:16];
                        frameBuf[2] <= word[15:8];
                        frameBuf[3] <= word[7:0];
                        byteIdx     <= '0;
                        timer       <= '0;
                        tx          <= 1'b0;
                        state       <= txStart;
                    end
                end
                txStart: begin
                    if (bitEnd) begin
                        curByte <= frameBuf[byteIdx];
                        tx      <= frameBuf[byteIdx][0];
                        bitIdx  <= '0;
                        timer   <= '0;
                        state   <= txData;
                    end else begin
                        timer <= timer + timerBits'(1);
                    end
                end
                txData: begin
                    if (bitEnd) begin
                        timer <= '0;
                        if (bitIdx == 3'd7) begin
                            tx    <= 1'b1;
                            state <= txStop;
                        end else begin
                            tx     <= curByte[bitIdx + 3'd1];
                            bitIdx <= bitIdx + 3'd1;
                        end
                    end else begin
                        timer <= timer + timerBits'(1);
                    end
                end
                txStop: begin
                    if (bitEnd) begin
                        timer <= '0;
                        if (byteIdx == 2'd3) begin
                            state <= txHold;
                        end else begin
                            byteIdx <= byteIdx + 2'd1;
                            tx      <= 1'b0;
                            state   <= txStart;
                        end
                    end else begin
                        timer <= timer + timerBits'(1);
                    end
                end
                txHold: begin
                    // wait out the hold time, then for the button release
                    if (holdEnd) begin
                        if (btnN) begin
                            state <= txIdle;
                        end
                    end else begin
                        timer <= timer + timerBits'(1);
                    end
                end
                default: begin
                    tx    <= 1'b1;
                    state <= txIdle;
                end
            endcase
        end
    end

    lineIdleHigh: assert property (
        @(posedge clk) disable iff (!rstN)
        (state inside {txIdle, txHold}) |-> tx
    ) else $error("tx low outside a frame");

endmodule

//--- run.sh
#!/bin/sh
# builds the debugSoc testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module debugSocTb -f src.f -o simDebugSoc &&
./obj_dir/simDebugSoc || exit 1

//--- src.f
rtl/memPkg.sv
rtl/uartPkg.sv
rtl/memCtrl.sv
rtl/laneAlign.sv
rtl/memArray.sv
rtl/wordDumpTx.sv
rtl/debugSoc.sv
bench/debugSocTb.sv
